/* include/sdio_dat_defines.svh */
`ifndef SDIO_DAT_DEFINES_SVH
`define SDIO_DAT_DEFINES_SVH

// data line crc, one per lane
`define SDIO_CRC_LEN    16
`define SDIO_CRC_POLY   16'h1021    // x^16 + x^12 + x^5 + 1, init 0

// dma byte and counter widths
`define SDIO_BYTE_BITS  8
`define SDIO_CNT_W      16

// number of dat lanes
`define SDIO_LANES      4

`endif

/* src/sdio_dat_pkg.sv */
`include "sdio_dat_defines.svh"

package sdio_dat_pkg;

    // one lane crc value
    typedef logic [`SDIO_CRC_LEN-1:0] crc_t;

    // receive fsm
    typedef enum logic [2:0] {
        IDLE            = 3'd0,
        RX_START_BIT    = 3'd1,     // timeout counter runs here
        RX_DATA_BYTE    = 3'd2,
        DMA_RX_BYTE_WR  = 3'd3,
        RX_CRC          = 3'd4,
        RX_END_BIT      = 3'd5,
        RX_BLK_GAP_STOP = 3'd6,
        RX_WAIT_DMA     = 3'd7      // drain dma buffer before done
    } rx_state_t;

endpackage

/* src/sdio_rx_lane_mux.sv */
`timescale 1ns/1ps
`include "sdio_dat_defines.svh"

module sdio_rx_lane_mux (
    input  logic                     width_4b_i,     // 0: 1-bit, 1: 4-bit
    input  logic [1:0]               pad_sel_i,      // pad for 1-bit mode
    input  logic [`SDIO_LANES-1:0]   dat_i,
    output logic [`SDIO_LANES-1:0]   lane_bit_o,
    output logic [`SDIO_LANES-1:0]   lane_use_o,
    output logic                     start_bit_o,
    output logic                     end_bit_o
);

    logic pad_bit;

    // single bit pad select
    always_comb begin
        case (pad_sel_i)
            2'b00:   pad_bit = dat_i[0];
            2'b01:   pad_bit = dat_i[1];
            2'b10:   pad_bit = dat_i[2];
            default: pad_bit = dat_i[3];
        endcase
    end

    // 1-bit mode puts the chosen pad on lane 0, unused lanes idle high
    always_comb begin
        if (width_4b_i) begin
            lane_bit_o = dat_i;
            lane_use_o = {`SDIO_LANES{1'b1}};
        end else begin
            lane_bit_o = {{(`SDIO_LANES-1){1'b1}}, pad_bit};
            lane_use_o = {{(`SDIO_LANES-1){1'b0}}, 1'b1};
        end
    end

    // start: all used lanes low, end: all used lanes high
    assign start_bit_o = ((lane_bit_o & lane_use_o) == '0);
    assign end_bit_o   = ((lane_bit_o | ~lane_use_o) == {`SDIO_LANES{1'b1}});

endmodule

/* src/sdio_crc16_lane.sv */
`timescale 1ns/1ps
`include "sdio_dat_defines.svh"

module sdio_crc16_lane
    import sdio_dat_pkg::*;
(
    input  logic sd_clk,
    input  logic rstn,
    input  logic sd_rst_i,
    input  logic clear_i,   // block start
    input  logic shift_i,   // one data bit on this lane
    input  logic bit_i,
    output crc_t crc_o
);

    crc_t crc_q;
    logic fb;

    assign fb = bit_i ^ crc_q[`SDIO_CRC_LEN-1];

    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            crc_q <= '0;
        end else if (sd_rst_i || clear_i) begin
            crc_q <= '0;
        end else if (shift_i) begin
            // msb-first serial division
            crc_q <= {crc_q[`SDIO_CRC_LEN-2:0], 1'b0} ^ (fb ? crc_t'(`SDIO_CRC_POLY) : '0);
        end
    end

    assign crc_o = crc_q;

    // clear comes from RX_START_BIT, shift from RX_DATA_BYTE
    a_clear_shift_excl: assert property (
        @(posedge sd_clk) disable iff (!rstn) !(clear_i && shift_i)
    );

endmodule

/* src/sdio_rx_crc_check.sv */
`timescale 1ns/1ps
`include "sdio_dat_defines.svh"

module sdio_rx_crc_check
    import sdio_dat_pkg::*;
(
    input  logic                     sd_clk,
    input  logic                     rstn,
    input  logic                     sd_rst_i,
    input  logic                     clear_i,
    input  logic                     cmp_i,      // one received crc bit per lane
    input  logic [3:0]               idx_i,      // crc bit index with 0 at the msb
    input  logic [`SDIO_LANES-1:0]   lane_bit_i,
    input  logic [`SDIO_LANES-1:0]   lane_use_i,
    input  crc_t                     crc0_i,
    input  crc_t                     crc1_i,
    input  crc_t                     crc2_i,
    input  crc_t                     crc3_i,
    output logic                     crc_err_o
);

    crc_t                   crc_a [`SDIO_LANES];
    logic [`SDIO_LANES-1:0] lane_miss;
    logic                   err_q;

    assign crc_a = '{crc0_i, crc1_i, crc2_i, crc3_i};

    // per lane compare of the expected crc bit
    always_comb begin
        logic [3:0] pos;
        pos = 4'(`SDIO_CRC_LEN - 1) - idx_i;
        for (int l = 0; l < `SDIO_LANES; l++) begin
            lane_miss[l] = lane_use_i[l] && (lane_bit_i[l] != crc_a[l][pos]);
        end
    end

    // sticky for the whole block
    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            err_q <= 1'b0;
        end else if (sd_rst_i || clear_i) begin
            err_q <= 1'b0;
        end else if (cmp_i && (lane_miss != '0)) begin
            err_q <= 1'b1;
        end
    end

    assign crc_err_o = err_q;

    // each compare steps the index to the next crc bit
    a_idx_step: assert property (
        @(posedge sd_clk) disable iff (!rstn)
            (cmp_i && !sd_rst_i) |=> (idx_i == $past(idx_i) + 4'd1)
    );

endmodule

/* src/sdio_rx_ctrl.sv */
`timescale 1ns/1ps
`include "sdio_dat_defines.svh"

module sdio_rx_ctrl
    import sdio_dat_pkg::*;
(
    input  logic                         sd_clk,
    input  logic                         rstn,
    input  logic                         sd_rst_i,
    input  logic                         dat_start_i,
    input  logic                         rx_en_i,
    input  logic                         width_4b_i,
    input  logic [`SDIO_CNT_W-1:0]       block_size_i,
    input  logic [`SDIO_CNT_W-1:0]       block_count_i,    // 0: unbounded
    input  logic                         blk_gap_stop_i,
    input  logic                         blk_gap_clk_en_i,
    input  logic                         dma_rx_buf_rdy_i,
    input  logic                         dma_rx_buf_empty_i,
    output logic [`SDIO_BYTE_BITS-1:0]   dma_rx_buf_o,
    output logic                         dma_rx_buf_wr_o,
    input  logic [`SDIO_LANES-1:0]       lane_bit_i,
    input  logic                         start_bit_i,
    input  logic                         end_bit_i,
    input  logic                         crc_err_i,
    output logic                         crc_clear_o,
    output logic                         crc_shift_o,
    output logic                         crc_cmp_o,
    output logic [3:0]                   crc_idx_o,
    output logic                         dat_crc_err_event_o,
    output logic                         dat_end_err_event_o,
    output logic                         blk_gap_event_o,
    output logic                         dat_busy_o,
    output logic                         dat_done_o,
    output logic                         sd_clk_pause_o,
    output logic                         tmout_wait_rx_start_en_o
);

    localparam logic [3:0] CRC_LAST = 4'(`SDIO_CRC_LEN - 1);

    rx_state_t                st_q, st_d;
    logic [2:0]               bit_cnt;
    logic [`SDIO_CNT_W-1:0]   byte_cnt, blk_cnt;
    logic [3:0]               crc_cnt;
    logic                     last_bit, last_byte, last_blk, last_crc;
    logic                     end_sample;

    assign last_bit   = (bit_cnt == (width_4b_i ? 3'd1 : 3'd7));  // 2 or 8 samples per byte
    assign last_byte  = (byte_cnt == block_size_i);
    assign last_blk   = (block_count_i != '0) && (blk_cnt == block_count_i);
    assign last_crc   = (crc_cnt == CRC_LAST);
    assign end_sample = (st_q == RX_END_BIT) && rx_en_i;

    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            st_q <= IDLE;
        end else if (sd_rst_i) begin
            st_q <= IDLE;
        end else begin
            st_q <= st_d;
        end
    end

    always_comb begin
        st_d = st_q;
        case (st_q)
            IDLE: begin
                if (dat_start_i)
                    st_d = RX_START_BIT;
            end
            RX_START_BIT: begin
                if (rx_en_i && start_bit_i)
                    st_d = RX_DATA_BYTE;
            end
            RX_DATA_BYTE: begin
                if (rx_en_i && last_bit)
                    st_d = DMA_RX_BYTE_WR;
            end
            DMA_RX_BYTE_WR: begin
                if (dma_rx_buf_rdy_i)
                    st_d = last_byte ? RX_CRC : RX_DATA_BYTE;
            end
            RX_CRC: begin
                if (rx_en_i && last_crc)
                    st_d = RX_END_BIT;
            end
            RX_END_BIT: begin
                if (rx_en_i)
                    st_d = RX_BLK_GAP_STOP;
            end
            RX_BLK_GAP_STOP: begin
                if (last_blk)
                    st_d = RX_WAIT_DMA;
                else if (!blk_gap_stop_i) // software releases the gap
                    st_d = RX_START_BIT;
            end
            RX_WAIT_DMA: begin
                if (dma_rx_buf_empty_i)
                    st_d = IDLE;
            end
            default: st_d = IDLE;
        endcase
    end

    // bit, byte, crc and block counters
    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
            blk_cnt  <= '0;
            crc_cnt  <= '0;
        end else if (sd_rst_i || (st_q == IDLE)) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
            blk_cnt  <= '0;
            crc_cnt  <= '0;
        end else begin
            case (st_q)
                RX_START_BIT: begin
                    bit_cnt  <= '0;
                    byte_cnt <= '0;
                    crc_cnt  <= '0;
                end
                RX_DATA_BYTE: begin
                    if (rx_en_i) begin
                        if (last_bit) begin
                            bit_cnt  <= '0;
                            byte_cnt <= byte_cnt + 1'b1;  // counts completed bytes
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                RX_CRC: begin
                    if (rx_en_i)
                        crc_cnt <= crc_cnt + 1'b1;
                end
                RX_END_BIT: begin
                    if (rx_en_i)
                        blk_cnt <= blk_cnt + 1'b1;
                end
                default: ;
            endcase
        end
    end

    // byte assembly, msb first, high nibble first in 4-bit mode
    always_ff @(posedge sd_clk) begin
        if ((st_q == RX_DATA_BYTE) && rx_en_i) begin
            if (width_4b_i)
                dma_rx_buf_o <= {dma_rx_buf_o[3:0], lane_bit_i};
            else
                dma_rx_buf_o <= {dma_rx_buf_o[`SDIO_BYTE_BITS-2:0], lane_bit_i[0]};
        end
    end

    // write strobe one cycle after rdy is seen
    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            dma_rx_buf_wr_o <= 1'b0;
        end else if (sd_rst_i) begin
            dma_rx_buf_wr_o <= 1'b0;
        end else begin
            dma_rx_buf_wr_o <= (st_q == DMA_RX_BYTE_WR) && dma_rx_buf_rdy_i;
        end
    end

    assign crc_clear_o = (st_q == RX_START_BIT);
    assign crc_shift_o = (st_q == RX_DATA_BYTE) && rx_en_i;
    assign crc_cmp_o   = (st_q == RX_CRC) && rx_en_i;
    assign crc_idx_o   = crc_cnt;

    // events land on the end bit sample
    assign dat_crc_err_event_o = end_sample && crc_err_i;
    assign dat_end_err_event_o = end_sample && !end_bit_i;
    assign blk_gap_event_o     = end_sample;

    assign dat_busy_o = (st_q != IDLE);
    assign dat_done_o = (st_q == RX_WAIT_DMA) && dma_rx_buf_empty_i;

    // hold the card clock on dma back-pressure or a stopped gap
    assign sd_clk_pause_o = (st_q == DMA_RX_BYTE_WR) ||
                            ((st_q == RX_BLK_GAP_STOP) && !blk_gap_clk_en_i);

    assign tmout_wait_rx_start_en_o = (st_q == RX_START_BIT);

    a_wr_single: assert property (
        @(posedge sd_clk) disable iff (!rstn) dma_rx_buf_wr_o |=> !dma_rx_buf_wr_o
    );

endmodule

/* src/sdio_rx_top.sv */
`timescale 1ns/1ps
`include "sdio_dat_defines.svh"

module sdio_rx_top
    import sdio_dat_pkg::*;
(
    input  logic                         sd_clk,
    input  logic                         rstn,
    input  logic                         sd_rst_i,
    input  logic [`SDIO_CNT_W-1:0]       block_size_i,
    input  logic [`SDIO_CNT_W-1:0]       block_count_i,
    input  logic                         width_4b_i,
    input  logic [1:0]                   pad_sel_i,
    input  logic                         blk_gap_stop_i,
    input  logic                         blk_gap_clk_en_i,
    input  logic                         dat_start_i,
    input  logic                         rx_en_i,
    input  logic [`SDIO_LANES-1:0]       dat_i,
    input  logic                         dma_rx_buf_rdy_i,
    input  logic                         dma_rx_buf_empty_i,
    output logic [`SDIO_BYTE_BITS-1:0]   dma_rx_buf_o,
    output logic                         dma_rx_buf_wr_o,
    output logic                         dat_crc_err_event_o,
    output logic                         dat_end_err_event_o,
    output logic                         blk_gap_event_o,
    output logic                         dat_busy_o,
    output logic                         dat_done_o,
    output logic                         sd_clk_pause_o,
    output logic                         tmout_wait_rx_start_en_o
);

    logic [`SDIO_LANES-1:0] lane_bit, lane_use;
    logic                   start_bit, end_bit;
    logic                   crc_clear, crc_shift, crc_cmp, crc_err;
    logic [3:0]             crc_idx;
    crc_t                   lane_crc [`SDIO_LANES];

    sdio_rx_lane_mux u_lane_mux (
        .width_4b_i  (width_4b_i),
        .pad_sel_i   (pad_sel_i),
        .dat_i       (dat_i),
        .lane_bit_o  (lane_bit),
        .lane_use_o  (lane_use),
        .start_bit_o (start_bit),
        .end_bit_o   (end_bit)
    );

    // one crc register per dat lane
    for (genvar g = 0; g < `SDIO_LANES; g++) begin : g_crc
        sdio_crc16_lane u_crc (
            .sd_clk   (sd_clk),
            .rstn     (rstn),
            .sd_rst_i (sd_rst_i),
            .clear_i  (crc_clear),
            .shift_i  (crc_shift & lane_use[g]),
            .bit_i    (lane_bit[g]),
            .crc_o    (lane_crc[g])
        );
    end

    sdio_rx_crc_check u_crc_check (
        .sd_clk     (sd_clk),
        .rstn       (rstn),
        .sd_rst_i   (sd_rst_i),
        .clear_i    (crc_clear),
        .cmp_i      (crc_cmp),
        .idx_i      (crc_idx),
        .lane_bit_i (lane_bit),
        .lane_use_i (lane_use),
        .crc0_i     (lane_crc[0]),
        .crc1_i     (lane_crc[1]),
        .crc2_i     (lane_crc[2]),
        .crc3_i     (lane_crc[3]),
        .crc_err_o  (crc_err)
    );

    sdio_rx_ctrl u_ctrl (
        .sd_clk                   (sd_clk),
        .rstn                     (rstn),
        .sd_rst_i                 (sd_rst_i),
        .dat_start_i              (dat_start_i),
        .rx_en_i                  (rx_en_i),
        .width_4b_i               (width_4b_i),
        .block_size_i             (block_size_i),
        .block_count_i            (block_count_i),
        .blk_gap_stop_i           (blk_gap_stop_i),
        .blk_gap_clk_en_i         (blk_gap_clk_en_i),
        .dma_rx_buf_rdy_i         (dma_rx_buf_rdy_i),
        .dma_rx_buf_empty_i       (dma_rx_buf_empty_i),
        .dma_rx_buf_o             (dma_rx_buf_o),
        .dma_rx_buf_wr_o          (dma_rx_buf_wr_o),
        .lane_bit_i               (lane_bit),
        .start_bit_i              (start_bit),
        .end_bit_i                (end_bit),
        .crc_err_i                (crc_err),
        .crc_clear_o              (crc_clear),
        .crc_shift_o              (crc_shift),
        .crc_cmp_o                (crc_cmp),
        .crc_idx_o                (crc_idx),
        .dat_crc_err_event_o      (dat_crc_err_event_o),
        .dat_end_err_event_o      (dat_end_err_event_o),
        .blk_gap_event_o          (blk_gap_event_o),
        .dat_busy_o               (dat_busy_o),
        .dat_done_o               (dat_done_o),
        .sd_clk_pause_o           (sd_clk_pause_o),
        .tmout_wait_rx_start_en_o (tmout_wait_rx_start_en_o)
    );

endmodule

/* verif/sdio_rx_tb.sv */
`timescale 1ns/1ps
`include "sdio_dat_defines.svh"

module sdio_rx_tb;

    logic sd_clk = 1'b0, rstn, sd_rst_i, width_4b_i, blk_gap_stop_i, blk_gap_clk_en_i;
    logic dat_start_i, rx_en_i, dma_rx_buf_rdy_i, dma_rx_buf_empty_i;
    logic [15:0] block_size_i, block_count_i;
    logic [1:0] pad_sel_i;
    logic [3:0] dat_i;
    logic [7:0] dma_rx_buf_o;
    logic dma_rx_buf_wr_o, crc_ev, end_ev, gap_ev, busy, done, pause, tmout_en;

    logic [15:0] lfsr_q = 16'd50;
    logic [6:0]  frame_q [$];      // fields {last, kind, nibble} where kind 0 start 1 data 2 crc 3 end
    logic [7:0]  exp_q [$];
    bit [15:0]   crc_bad, end_bad;  // per block expectations
    bit take_n, take_last_n, dma_clr_n, dma_wait, rdy_hold, gap_hold, busy_chk, tmo_active;
    int wr_cnt, gap_cnt, done_cnt, value_errs, other_errs, tmo_cyc, tmo_limit;
    logic [7:0] exp_b;

    sdio_rx_top UUT (
        .sd_clk(sd_clk), .rstn(rstn), .sd_rst_i(sd_rst_i), .block_size_i(block_size_i),
        .block_count_i(block_count_i), .width_4b_i(width_4b_i), .pad_sel_i(pad_sel_i),
        .blk_gap_stop_i(blk_gap_stop_i), .blk_gap_clk_en_i(blk_gap_clk_en_i),
        .dat_start_i(dat_start_i), .rx_en_i(rx_en_i), .dat_i(dat_i),
        .dma_rx_buf_rdy_i(dma_rx_buf_rdy_i), .dma_rx_buf_empty_i(dma_rx_buf_empty_i),
        .dma_rx_buf_o(dma_rx_buf_o), .dma_rx_buf_wr_o(dma_rx_buf_wr_o),
        .dat_crc_err_event_o(crc_ev), .dat_end_err_event_o(end_ev), .blk_gap_event_o(gap_ev),
        .dat_busy_o(busy), .dat_done_o(done), .sd_clk_pause_o(pause),
        .tmout_wait_rx_start_en_o(tmout_en)
    );

    always #4 sd_clk = ~sd_clk;

    function automatic logic lfsr_bit();
        logic nb;
        nb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];  // taps 16,14,13,11
        lfsr_q = {lfsr_q[14:0], nb};
        return nb;
    endfunction

    function automatic logic [7:0] lfsr_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[6:0], lfsr_bit()};
        return v;
    endfunction

    function automatic logic [15:0] crc_step(input logic [15:0] c, input logic b);
        return (b ^ c[15]) ? ({c[14:0], 1'b0} ^ `SDIO_CRC_POLY) : {c[14:0], 1'b0};
    endfunction

    // random idle pads around the selected one
    function automatic logic [3:0] pad_nib(input logic [1:0] pad, input logic b);
        logic [3:0] n;
        n = 4'(lfsr_bits(4));
        n[pad] = b;
        return n;
    endfunction

    task automatic expect_true(input bit ok, input string msg);
        assert (ok) else begin
            value_errs++;
            $display("CHECK FAILED @ %0t: %s", $time, msg);
        end
    endtask

    task automatic outputs_idle();
        expect_true(!dma_rx_buf_wr_o && !crc_ev && !end_ev && !gap_ev && !busy && !done
                    && !pause && !tmout_en, "control outputs not low in IDLE");
    endtask

    // card side frames for every block and the expected bytes into exp_q
    task automatic build_xfer(input logic w4, input logic [1:0] pad, input int size,
                              input int count, input bit corrupt_en, input int bad_end_blk);
        logic [15:0] crc [4];
        logic [7:0] d;
        logic [3:0] n;
        int cidx, cl;
        for (int b = 0; b < count; b++) begin
            crc = '{default: '0};
            crc_bad[b] = corrupt_en ? lfsr_bit() : 1'b0;
            end_bad[b] = (b == bad_end_blk);
            cidx = int'(lfsr_bits(4));
            cl = w4 ? int'(lfsr_bits(2)) : int'(pad);
            frame_q.push_back({3'b000, w4 ? 4'h0 : pad_nib(pad, 1'b0)});
            for (int i = 0; i < size; i++) begin
                d = lfsr_bits(8);
                exp_q.push_back(d);
                if (w4) begin
                    for (int h = 1; h >= 0; h--) begin  // high nibble first
                        n = d[h*4 +: 4];
                        for (int l = 0; l < 4; l++)
                            crc[l] = crc_step(crc[l], n[l]);
                        frame_q.push_back({(h == 0), 2'd1, n});
                    end
                end else begin
                    for (int k = 7; k >= 0; k--) begin
                        crc[0] = crc_step(crc[0], d[k]);
                        frame_q.push_back({(k == 0), 2'd1, pad_nib(pad, d[k])});
                    end
                end
            end
            for (int i = 0; i < 16; i++) begin
                if (w4)
                    n = {crc[3][15-i], crc[2][15-i], crc[1][15-i], crc[0][15-i]};
                else
                    n = pad_nib(pad, crc[0][15-i]);
                if (crc_bad[b] && i == cidx)
                    n[cl] = ~n[cl];
                frame_q.push_back({3'b010, n});
            end
            n = w4 ? 4'hF : pad_nib(pad, 1'b1);
            if (end_bad[b])
                n[w4 ? 0 : pad] = 1'b0;
            frame_q.push_back({3'b011, n});
        end
    endtask

    // card and dma side drivers
    always @(posedge sd_clk) begin
        if (take_n && frame_q.size() > 0)
            void'(frame_q.pop_front());
        if (take_last_n)
            dma_wait = 1'b1;
        else if (dma_clr_n)
            dma_wait = 1'b0;
        dat_i <= (frame_q.size() > 0) ? frame_q[0][3:0] : 4'hF;
        rx_en_i <= lfsr_bit();
        dma_rx_buf_rdy_i <= rdy_hold ? 1'b0 : lfsr_bit();
    end

    // monitor on the falling edge
    always @(negedge sd_clk) begin
        take_n = 1'b0;
        if (rstn && !sd_rst_i && rx_en_i && frame_q.size() > 0)
            take_n = (frame_q[0][5:4] == 2'd0) ? tmout_en : (busy && !pause);
        take_last_n = take_n && frame_q[0][6];
        dma_clr_n = dma_wait && dma_rx_buf_rdy_i;
        if (rstn) begin
            if (dma_wait)
                expect_true(pause, "no clock pause while a byte waits for dma");
            if (dma_rx_buf_wr_o) begin
                if (exp_q.size() == 0) begin
                    other_errs++;
                    $display("a dma write came with no byte left to compare");
                end else begin
                    exp_b = exp_q.pop_front();
                    expect_true(dma_rx_buf_o == exp_b, $sformatf("byte %0d: got %h, want %h",
                                wr_cnt, dma_rx_buf_o, exp_b));
                end
                wr_cnt++;
            end
            if (gap_ev) begin
                expect_true(crc_ev == crc_bad[gap_cnt[3:0]], "crc error event mismatch");
                expect_true(end_ev == end_bad[gap_cnt[3:0]], "end bit error event mismatch");
                gap_cnt++;
            end else begin
                expect_true(!crc_ev && !end_ev, "error event outside the end bit sample");
            end
            if (gap_hold)
                expect_true(pause == !blk_gap_clk_en_i && !dma_rx_buf_wr_o && !tmout_en,
                            "block gap stop not held");
            if (busy_chk)
                expect_true(!busy, "busy still high after done");
            busy_chk = done;
            if (done)
                done_cnt++;
        end
        if (tmo_active) begin
            tmo_cyc++;
            if (tmo_cyc > tmo_limit) begin
                $display("timeout: transfer did not finish within %0d cycles", tmo_limit);
                $display("TESTS FAILED");
                $finish;
            end
        end
    end

    task automatic start_xfer(input logic w4, input logic [1:0] pad, input int size,
                              input int count, input int cfg_count, input bit stop,
                              input bit clk_en, input bit corrupt_en, input int bad_end_blk);
        @(negedge sd_clk);
        wr_cnt = 0;
        gap_cnt = 0;
        done_cnt = 0;
        build_xfer(w4, pad, size, count, corrupt_en, bad_end_blk);
        tmo_limit = frame_q.size() * 4 + count * 64;  // bits x 4 + blocks x 64
        tmo_cyc = 0;
        tmo_active = 1'b1;
        @(posedge sd_clk);
        width_4b_i <= w4;
        pad_sel_i <= pad;
        block_size_i <= 16'(size);
        block_count_i <= 16'(cfg_count);
        blk_gap_stop_i <= stop;
        blk_gap_clk_en_i <= clk_en;
        dat_start_i <= 1'b1;
        @(posedge sd_clk);
        dat_start_i <= 1'b0;
        @(negedge sd_clk);
        expect_true(busy, "busy did not rise after start");
    endtask

    task automatic run_xfer(input logic w4, input logic [1:0] pad, input int size,
                            input int count, input bit stop, input bit clk_en,
                            input bit corrupt_en, input int bad_end_blk,
                            input bit hold_rdy, input bit hold_empty);
        @(posedge sd_clk);
        dma_rx_buf_empty_i <= !hold_empty;
        start_xfer(w4, pad, size, count, count, stop, clk_en, corrupt_en, bad_end_blk);
        if (hold_rdy) begin
            while (wr_cnt < 2)
                @(posedge sd_clk);
            @(negedge sd_clk) rdy_hold = 1'b1;
            repeat (20) @(negedge sd_clk);
            rdy_hold = 1'b0;
        end
        for (int b = 0; stop && b < count - 1; b++) begin
            while (gap_cnt <= b)
                @(posedge sd_clk);
            gap_hold = 1'b1;
            repeat (12) @(posedge sd_clk);
            gap_hold = 1'b0;
            blk_gap_stop_i <= 1'b0;
            @(posedge sd_clk);
            blk_gap_stop_i <= 1'b1;
        end
        if (hold_empty) begin
            while (gap_cnt < count)
                @(posedge sd_clk);
            repeat (10) @(posedge sd_clk);
            expect_true(done_cnt == 0, "done before the dma buffer drained");
            dma_rx_buf_empty_i <= 1'b1;
        end
        while (done_cnt == 0)
            @(posedge sd_clk);
        repeat (2) @(posedge sd_clk);
        tmo_active = 1'b0;
        expect_true(wr_cnt == size * count, "wrong number of dma writes");
        expect_true(gap_cnt == count && done_cnt == 1, "wrong gap or done pulse count");
        expect_true(exp_q.size() == 0, "bytes left unreceived");
    endtask

    initial begin
        {rstn, sd_rst_i, width_4b_i, blk_gap_stop_i, blk_gap_clk_en_i, dat_start_i} = '0;
        {rx_en_i, dma_rx_buf_rdy_i, block_size_i, block_count_i, pad_sel_i} = '0;
        dma_rx_buf_empty_i = 1'b1;
        dat_i = 4'hF;
        repeat (2) @(posedge sd_clk);
        rstn <= 1'b1;
        @(negedge sd_clk);
        outputs_idle();
        for (int p = 0; p < 4; p++)
            run_xfer(1'b0, p[1:0], 4, 2, 1'b0, 1'b1, 1'b0, -1, 1'b0, 1'b0);
        run_xfer(1'b1, 2'd0, 6, 3, 1'b0, 1'b1, 1'b0, -1, 1'b0, 1'b0);
        run_xfer(1'b1, 2'd0, 3, 4, 1'b0, 1'b1, 1'b1, 2, 1'b0, 1'b0);
        run_xfer(1'b0, 2'd2, 2, 4, 1'b0, 1'b1, 1'b1, 1, 1'b0, 1'b0);
        run_xfer(1'b0, 2'd1, 3, 3, 1'b1, 1'b0, 1'b0, -1, 1'b0, 1'b0);
        run_xfer(1'b1, 2'd0, 3, 3, 1'b1, 1'b1, 1'b0, -1, 1'b0, 1'b0);
        run_xfer(1'b1, 2'd0, 6, 2, 1'b0, 1'b1, 1'b0, -1, 1'b1, 1'b1);
        // soft reset in the middle of an unbounded transfer
        start_xfer(1'b1, 2'd0, 4, 3, 0, 1'b0, 1'b1, 1'b0, -1);
        while (wr_cnt < 6)
            @(posedge sd_clk);
        sd_rst_i <= 1'b1;
        @(posedge sd_clk);
        sd_rst_i <= 1'b0;
        @(negedge sd_clk);
        frame_q.delete();
        exp_q.delete();
        dma_wait = 1'b0;
        tmo_active = 1'b0;
        outputs_idle();
        run_xfer(1'b0, 2'd3, 4, 2, 1'b0, 1'b1, 1'b0, -1, 1'b0, 1'b0);
        $display("errors: %0d check, %0d other", value_errs, other_errs);
        if (value_errs + other_errs == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

/* src.f */
+incdir+include
src/sdio_dat_pkg.sv
src/sdio_rx_lane_mux.sv
src/sdio_crc16_lane.sv
src/sdio_rx_crc_check.sv
src/sdio_rx_ctrl.sv
src/sdio_rx_top.sv
verif/sdio_rx_tb.sv

/* Bender.yml */
package:
  name: sdio_rx

sources:
  - include_dirs:
      - include
    files:
      - src/sdio_dat_pkg.sv
      - src/sdio_rx_lane_mux.sv
      - src/sdio_crc16_lane.sv
      - src/sdio_rx_crc_check.sv
      - src/sdio_rx_ctrl.sv
      - src/sdio_rx_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/sdio_rx_tb.sv
